// ==== bpu_pred.f ====
source/bpu_pkg.sv
source/bpu_btb.sv
source/bpu_dir_pred.sv
source/bpu_ras.sv
source/bpu.sv
source/bpu_fetch_queue.sv
source/bpu_top.sv
tb/tb_bpu_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the bpu testbench with Verilator, run it, decide on the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/tb_sim

verilator --binary --timing -j 0 --top-module tb_bpu_top \
    -f bpu_pred.f --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "all tests passed" "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1

// ==== tb/tb_bpu_top.sv ====
// random stimulus with seed 40, model assumes default table sizes and a 16-pc pool near INIT_PC
module tb_bpu_top import bpu_pkg::*; ();

    localparam int BTB_IDX_W = 9;
    localparam int PHT_PC_W = 8;
    localparam int RAS_DEPTH = 8;
    localparam int FQ_DEPTH = 4;
    localparam int RESET_CYCLES = 2;
    localparam int QUIET_CYCLES = 40;             // no training, no flush at first
    localparam int NUM_CYCLES = 4000;
    localparam int TIMEOUT_CYCLES = 2 * (NUM_CYCLES + RESET_CYCLES);
    localparam int BTB_DEPTH = 1 << BTB_IDX_W;
    localparam int PHT_DEPTH = 1 << (HIST_W + PHT_PC_W);
    localparam int RAS_PTR_W = $clog2(RAS_DEPTH);

    logic                clk;
    logic                rst_n;
    logic                flush_i;
    logic [31:0]         redir_pc_i;
    correct_info_t [1:0] correct_infos_i;
    logic                fetch_valid_o;
    logic                fetch_ready_i;
    fetch_bundle_t       fetch_bundle_o;

    // reference copies of every table
    btb_entry_t        m_btb [2][BTB_DEPTH];
    logic [HIST_W-1:0] m_bht [2][BTB_DEPTH];
    logic [1:0]        m_pht [2][PHT_DEPTH];
    logic [31:0]       m_ras [RAS_DEPTH];
    logic [RAS_PTR_W-1:0] m_ras_top;
    logic [31:0]       m_pc;
    logic [31:0]       chain_pc;                  // pc the next output bundle must carry
    logic [31:0]       pool [16];                 // pcs and targets for training

    fetch_bundle_t exp_q [$];                     // bundles inside the queue, in order
    int cycle_cnt = 0;
    int n_checked = 0;

    bpu_top #(
        .BTB_IDX_W (BTB_IDX_W),
        .PHT_PC_W  (PHT_PC_W),
        .RAS_DEPTH (RAS_DEPTH),
        .FQ_DEPTH  (FQ_DEPTH)
    ) i_bpu_top (
        .clk             (clk),
        .rst_n           (rst_n),
        .flush_i         (flush_i),
        .redir_pc_i      (redir_pc_i),
        .correct_infos_i (correct_infos_i),
        .fetch_valid_o   (fetch_valid_o),
        .fetch_ready_i   (fetch_ready_i),
        .fetch_bundle_o  (fetch_bundle_o)
    );

    always #10 clk = ~clk;

    // hard stop, main loop is bounded but a stuck clock is not
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("tests failed");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic check_bundle(input fetch_bundle_t got, input fetch_bundle_t exp);
        if (got !== exp) begin
            $display("Fail fetch_bundle_o got %h expected %h", got, exp);
            $display("tests failed");
            $fatal(1, "bundle mismatch at cycle %0d", cycle_cnt);
        end
    endtask

    task automatic check_pc(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail fetch_bundle_o.pc got %h expected %h", got, exp);
            $display("tests failed");
            $fatal(1, "pc mismatch at cycle %0d", cycle_cnt);
        end
    endtask

    task automatic check_valid(input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail fetch_valid_o got %h expected %h", got, exp);
            $display("tests failed");
            $fatal(1, "valid mismatch at cycle %0d", cycle_cnt);
        end
    endtask

    // pc[11:3] xor pc[17:9] for a 9 bit index
    function automatic logic [BTB_IDX_W-1:0] idx_of(input logic [31:0] pc);
        logic [31:0] folded;
        folded = (pc >> 3) ^ (pc >> 9);
        return folded[BTB_IDX_W-1:0];
    endfunction

    // plain 2-bit saturating counter
    function automatic logic [1:0] sat_step(input logic [1:0] c, input logic t);
        if (t) begin
            return (c == 2'b11) ? c : c + 2'd1;
        end
        return (c == 2'b00) ? c : c - 2'd1;
    endfunction

    // fetch pc that must follow a bundle, first usable taken slot wins
    function automatic logic [31:0] follow_pc(input fetch_bundle_t b);
        if (b.mask[0] && b.predict_infos[0].taken) begin
            return b.predict_infos[0].target_pc;
        end
        if (b.mask[1] && b.predict_infos[1].taken) begin
            return b.predict_infos[1].target_pc;
        end
        return {b.pc[31:3], 3'b000} + 32'd8;
    endfunction

    // expected bundle and next fetch pc for the model pc
    task automatic predict_pair(output fetch_bundle_t b, output logic [31:0] npc);
        btb_entry_t           e;
        logic [BTB_IDX_W-1:0] ix;
        logic [HIST_W-1:0]    h;
        logic [1:0]           c;
        logic                 hit;
        logic                 tk [2];
        logic [31:0]          tg [2];
        logic [31:0]          pair_next;
        ix = idx_of(m_pc);
        pair_next = {m_pc[31:3], 3'b000} + 32'd8;
        b.pc = m_pc;
        for (int i = 0; i < 2; i++) begin
            e = m_btb[i][ix];
            h = m_bht[i][ix];
            c = m_pht[i][{h, m_pc[3 +: PHT_PC_W]}];
            hit = e.valid && (e.tag == m_pc[12 +: TAG_W]);
            tk[i] = hit && (e.br_type != BR_NORMAL || c[1]);
            tg[i] = (e.br_type == BR_RET) ? m_ras[m_ras_top] : e.target;
            b.predict_infos[i].target_pc = tg[i];
            if (tk[i]) begin
                b.predict_infos[i].next_pc = tg[i];
            end else begin
                b.predict_infos[i].next_pc = (i == 0) ? {m_pc[31:3], 3'b100} : pair_next;
            end
            b.predict_infos[i].is_branch = hit;
            b.predict_infos[i].br_type = e.br_type;
            b.predict_infos[i].taken = tk[i];
            b.predict_infos[i].cnt = c;
            b.predict_infos[i].history = h;
            b.predict_infos[i].need_update = !hit;
        end
        b.mask[0] = !m_pc[2];                     // odd-word pc skips slot 0
        b.mask[1] = !(tk[0] && !m_pc[2]);
        if (tk[0] && !m_pc[2]) begin
            npc = tg[0];
        end else if (tk[1]) begin
            npc = tg[1];
        end else begin
            npc = pair_next;
        end
    endtask

    task automatic train_tables(input correct_info_t c0, input correct_info_t c1);
        correct_info_t        u;
        btb_entry_t           e;
        logic [BTB_IDX_W-1:0] ix;
        logic                 bank;
        u = c0.update ? c0 : c1;                  // slot 0 first
        if (u.update) begin
            ix = idx_of(u.pc);
            bank = u.pc[2];
            if (u.type_miss || u.target_miss) begin
                e.valid = u.is_branch;
                e.br_type = u.br_type;
                e.tag = u.pc[12 +: TAG_W];
                e.target = u.target_pc;
                m_btb[bank][ix] = e;
            end
            if (u.type_miss) begin
                m_bht[bank][ix] = {{(HIST_W-1){1'b0}}, u.taken};
            end else begin
                m_bht[bank][ix] = {u.history[HIST_W-2:0], u.taken};
            end
            m_pht[bank][{u.history, u.pc[3 +: PHT_PC_W]}] = sat_step(u.cnt, u.taken);
            if (u.br_type == BR_CALL) begin
                m_ras_top = m_ras_top + 1'b1;     // wraps over the oldest
                m_ras[m_ras_top] = u.pc + 32'd4;
            end else if (u.br_type == BR_RET) begin
                m_ras_top = m_ras_top - 1'b1;
            end
        end
    endtask

    // history and counter taken from the model, as the back end would report them
    function automatic correct_info_t make_correction(input logic quiet);
        correct_info_t c;
        logic [31:0]   r;
        logic [31:0]   t;
        r = $urandom;
        t = $urandom;
        c.update = !quiet && r[0];
        c.pc = pool[r[4:1]];
        c.taken = (r[6:5] != 2'b00) ^ c.pc[3];   // bias per pc, some saturate each way
        c.br_type = br_type_e'(r[8:7]);
        c.is_branch = (r[10:9] != 2'b00);
        c.type_miss = r[11];
        c.target_miss = r[12];
        c.history = m_bht[c.pc[2]][idx_of(c.pc)];
        c.cnt = m_pht[c.pc[2]][{c.history, c.pc[3 +: PHT_PC_W]}];
        c.target_pc = pool[t[3:0]];
        return c;
    endfunction

    task automatic drive_cycle(input logic quiet);
        logic [31:0] r;
        r = $urandom;
        fetch_ready_i = (r[1:0] != 2'b00);        // about 3 in 4 cycles
        flush_i = !quiet && (r[7:4] == 4'd0);
        redir_pc_i = pool[r[11:8]];
        for (int s = 0; s < 2; s++) begin
            correct_infos_i[s] = make_correction(quiet);
        end
    endtask

    // what happens at the coming edge, from pre-edge values
    task automatic model_cycle();
        fetch_bundle_t pred;
        logic [31:0]   npc;
        logic          fq_ready;
        logic          out_valid;
        predict_pair(pred, npc);
        fq_ready = (exp_q.size() < FQ_DEPTH);
        out_valid = (exp_q.size() != 0) && !flush_i;
        check_valid(fetch_valid_o, out_valid);
        if (out_valid && fetch_ready_i) begin
            check_pc(fetch_bundle_o.pc, chain_pc);
            check_bundle(fetch_bundle_o, exp_q[0]);
            chain_pc = follow_pc(exp_q[0]);
            exp_q.pop_front();
            n_checked++;
        end
        if (flush_i) begin
            exp_q.delete();                       // pre-flush bundles are dropped
            m_pc = redir_pc_i;
            chain_pc = redir_pc_i;
        end else if (fq_ready) begin
            exp_q.push_back(pred);
            m_pc = npc;
        end
        train_tables(correct_infos_i[0], correct_infos_i[1]);
    endtask

    initial begin
        void'($urandom(40));
        clk = 1'b0;
        rst_n = 1'b0;
        flush_i = 1'b0;
        redir_pc_i = '0;
        correct_infos_i = '0;
        fetch_ready_i = 1'b0;
        for (int k = 0; k < 16; k++) begin
            pool[k] = INIT_PC + (32'(k) << 2);     // eight pairs from INIT_PC up
        end
        for (int b = 0; b < 2; b++) begin
            for (int i = 0; i < BTB_DEPTH; i++) begin
                m_btb[b][i] = '0;
                m_bht[b][i] = '0;
            end
            for (int i = 0; i < PHT_DEPTH; i++) begin
                m_pht[b][i] = '0;
            end
        end
        for (int i = 0; i < RAS_DEPTH; i++) begin
            m_ras[i] = '0;
        end
        m_ras_top = '1;                           // empty stack
        m_pc = INIT_PC;
        chain_pc = INIT_PC;

        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
        for (int n = 0; n < NUM_CYCLES; n++) begin
            drive_cycle(n < QUIET_CYCLES);
            #15;                                  // outputs settled, edge 3 units away
            model_cycle();
            @(posedge clk);
            #2;
        end

        $display("checked %0d fetch transfers in %0d cycles", n_checked, NUM_CYCLES);
        if (n_checked == 0) begin
            $display("no bundle ever reached the fetch side");
            $display("tests failed");
            $fatal(1, "no transfers");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

// ==== source/bpu_top.sv ====
// predictor plus fetch queue, tables zeroed at load, correction slot 0 has priority
module bpu_top import bpu_pkg::*; #(
    parameter int BTB_IDX_W = 9,
    parameter int PHT_PC_W  = 8,
    parameter int RAS_DEPTH = 8,
    parameter int FQ_DEPTH  = 4
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush_i,
    input  logic [31:0]         redir_pc_i,
    input  correct_info_t [1:0] correct_infos_i,
    output logic                fetch_valid_o,
    input  logic                fetch_ready_i,
    output fetch_bundle_t       fetch_bundle_o
);
    logic          bp_valid;                  // predictor to queue
    logic          bp_ready;
    fetch_bundle_t bp_bundle;

    bpu #(
        .BTB_IDX_W (BTB_IDX_W),
        .PHT_PC_W  (PHT_PC_W),
        .RAS_DEPTH (RAS_DEPTH)
    ) i_bpu (
        .clk             (clk),
        .rst_n           (rst_n),
        .flush_i         (flush_i),
        .redir_pc_i      (redir_pc_i),
        .correct_infos_i (correct_infos_i),
        .ready_i         (bp_ready),
        .valid_o         (bp_valid),
        .bundle_o        (bp_bundle)
    );

    bpu_fetch_queue #(
        .FQ_DEPTH (FQ_DEPTH)
    ) i_bpu_fetch_queue (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush_i      (flush_i),
        .in_valid_i   (bp_valid),
        .in_bundle_i  (bp_bundle),
        .in_ready_o   (bp_ready),
        .out_valid_o  (fetch_valid_o),
        .out_bundle_o (fetch_bundle_o),
        .out_ready_i  (fetch_ready_i)
    );

endmodule

// ==== source/bpu_fetch_queue.sv ====
// bundle fifo to fetch, flush empties it and blocks output that cycle, any depth >= 2
module bpu_fetch_queue import bpu_pkg::*; #(
    parameter int FQ_DEPTH = 4
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          flush_i,
    input  logic          in_valid_i,
    input  fetch_bundle_t in_bundle_i,
    output logic          in_ready_o,
    output logic          out_valid_o,
    output fetch_bundle_t out_bundle_o,
    input  logic          out_ready_i
);
    localparam int PTR_W = $clog2(FQ_DEPTH);
    localparam int CNT_W = $clog2(FQ_DEPTH + 1);

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    fetch_bundle_t mem [FQ_DEPTH];

    assign in_ready_o = (count != CNT_W'(FQ_DEPTH));
    assign out_valid_o = (count != '0) && !flush_i;  // stale entries never leave
    assign out_bundle_o = mem[rd_ptr];

    assign push = in_valid_i && in_ready_o;
    assign pop = out_valid_o && out_ready_i;

    always_ff @(posedge clk) begin
        if (!rst_n || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;        // push and pop together keep count
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_bundle_i;
        end
    end

endmodule

// ==== source/bpu.sv ====
// predictor core, one pair per cycle, first taken slot wins, ras trained by back end only
module bpu import bpu_pkg::*; #(
    parameter int BTB_IDX_W = 9,
    parameter int PHT_PC_W  = 8,
    parameter int RAS_DEPTH = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush_i,
    input  logic [31:0]         redir_pc_i,
    input  correct_info_t [1:0] correct_infos_i,
    input  logic                ready_i,
    output logic                valid_o,
    output fetch_bundle_t       bundle_o
);
    correct_info_t          upd;
    btb_entry_t             btb_wr_entry;
    btb_entry_t [1:0]       btb_entries;
    logic [1:0]             btb_hit;
    logic                   btb_we;
    logic [1:0][HIST_W-1:0] hist;
    logic [1:0][1:0]        cnt;
    logic [31:0]            ras_top;
    logic [31:0]            pc;
    logic [31:0]            pc_next;
    logic [31:0]            pc_add8;
    logic [1:0]             taken;
    logic [1:0][31:0]       target_pc;
    logic [1:0][31:0]       next_pc;

    // slot 1 only when slot 0 has nothing to train
    assign upd = correct_infos_i[0].update ? correct_infos_i[0] : correct_infos_i[1];

    assign btb_we = upd.update && (upd.type_miss || upd.target_miss);
    assign btb_wr_entry.valid = upd.is_branch;
    assign btb_wr_entry.br_type = upd.br_type;
    assign btb_wr_entry.tag = bpu_tag(upd.pc);
    assign btb_wr_entry.target = upd.target_pc;

    bpu_btb #(
        .BTB_IDX_W (BTB_IDX_W)
    ) i_bpu_btb (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_pc_i      (pc),
        .wr_en_i      (btb_we),
        .wr_pc_i      (upd.pc),
        .wr_entry_i   (btb_wr_entry),
        .rd_entries_o (btb_entries),
        .hit_o        (btb_hit)
    );

    bpu_dir_pred #(
        .BTB_IDX_W (BTB_IDX_W),
        .PHT_PC_W  (PHT_PC_W)
    ) i_bpu_dir_pred (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_pc_i (pc),
        .upd_i   (upd),
        .hist_o  (hist),
        .cnt_o   (cnt)
    );

    bpu_ras #(
        .RAS_DEPTH (RAS_DEPTH)
    ) i_bpu_ras (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_i      (upd.update && upd.br_type == BR_CALL),
        .pop_i       (upd.update && upd.br_type == BR_RET),
        .push_addr_i (upd.pc + 32'd4), // return lands after the call
        .top_o       (ras_top)
    );

    assign pc_add8 = {pc[31:3] + 29'd1, 3'b000};   // next aligned pair

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            // jumps, calls, returns always taken once in the btb
            taken[i] = btb_hit[i] && (btb_entries[i].br_type != BR_NORMAL || cnt[i][1]);
            target_pc[i] = (btb_entries[i].br_type == BR_RET) ? ras_top
                                                              : btb_entries[i].target;
        end
    end

    assign next_pc[0] = taken[0] ? target_pc[0] : {pc[31:3], 3'b100};
    assign next_pc[1] = taken[1] ? target_pc[1] : pc_add8;

    // slot 0 only counts on an even-word pc
    always_comb begin
        pc_next = pc_add8;
        if (taken[0] && !pc[2]) begin
            pc_next = next_pc[0];
        end else if (taken[1]) begin
            pc_next = next_pc[1];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= INIT_PC;
        end else if (flush_i) begin
            pc <= redir_pc_i;                 // redirect beats any transfer
        end else if (valid_o && ready_i) begin
            pc <= pc_next;                    // holds under back pressure
        end
    end

    assign valid_o = rst_n && !flush_i;

    assign bundle_o.pc = pc;
    assign bundle_o.mask = {!(taken[0] && !pc[2]), !pc[2]};

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            bundle_o.predict_infos[i].target_pc = target_pc[i];
            bundle_o.predict_infos[i].next_pc = next_pc[i];
            bundle_o.predict_infos[i].is_branch = btb_hit[i];
            bundle_o.predict_infos[i].br_type = btb_entries[i].br_type;
            bundle_o.predict_infos[i].taken = taken[i];
            bundle_o.predict_infos[i].cnt = cnt[i];
            bundle_o.predict_infos[i].history = hist[i];
            bundle_o.predict_infos[i].need_update = !btb_hit[i]; // miss, back end trains it
        end
    end

endmodule

// ==== source/bpu_ras.sv ====
// circular ras, depth a power of two, overflow drops the oldest, no repair on flush
module bpu_ras #(
    parameter int RAS_DEPTH = 8
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        push_i,
    input  logic        pop_i,
    input  logic [31:0] push_addr_i,
    output logic [31:0] top_o
);
    localparam int PTR_W = $clog2(RAS_DEPTH);

    logic [PTR_W-1:0] top_ptr;                 // last pushed entry
    logic [PTR_W-1:0] w_ptr;                   // next free slot, top_ptr + 1
    logic [31:0]      stack [RAS_DEPTH];

    initial begin
        for (int i = 0; i < RAS_DEPTH; i++) begin
            stack[i] = '0;
        end
    end

    assign top_o = stack[top_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            top_ptr <= '1;                    // empty, points below slot 0
            w_ptr <= '0;
        end else if (push_i) begin
            w_ptr <= w_ptr + 1'b1;            // wraps, oldest gets overwritten
            top_ptr <= w_ptr;
        end else if (pop_i) begin
            w_ptr <= top_ptr;
            top_ptr <= top_ptr - 1'b1;
        end
    end

    // payload write, no reset
    always_ff @(posedge clk) begin
        if (push_i) begin
            stack[w_ptr] <= push_addr_i;
        end
    end

endmodule

// ==== source/bpu_dir_pred.sv ====
// local history + 2-bit counter direction, trained from back end only, no speculative history
module bpu_dir_pred import bpu_pkg::*; #(
    parameter int BTB_IDX_W = 9,
    parameter int PHT_PC_W  = 8
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [31:0]            rd_pc_i,
    input  correct_info_t          upd_i,
    output logic [1:0][HIST_W-1:0] hist_o,
    output logic [1:0][1:0]        cnt_o
);
    localparam int BHT_DEPTH = 1 << BTB_IDX_W;
    localparam int PHT_IDX_W = HIST_W + PHT_PC_W;
    localparam int PHT_DEPTH = 1 << PHT_IDX_W;

    logic [31:0]          rd_fold;
    logic [31:0]          wr_fold;
    logic [BTB_IDX_W-1:0] bht_rd_idx;
    logic [BTB_IDX_W-1:0] bht_wr_idx;
    logic [PHT_IDX_W-1:0] pht_wr_idx;
    logic [HIST_W-1:0]    hist_new;
    logic                 wr_bank;

    logic [HIST_W-1:0] bht [2][BHT_DEPTH];
    logic [1:0]        pht [2][PHT_DEPTH];

    // 00/11 strong, 01/10 weak
    function automatic logic [1:0] next_cnt(input logic [1:0] cnt, input logic taken);
        case (cnt)
            2'b00:   return {1'b0, taken};    // strong nt steps to weak nt on taken
            2'b01:   return {taken, 1'b0};    // weak nt, to weak t or strong nt
            2'b10:   return {taken, 1'b1};    // weak t, to strong t or weak nt
            default: return {1'b1, taken};    // strong t steps to weak t
        endcase
    endfunction

    initial begin
        for (int b = 0; b < 2; b++) begin
            for (int i = 0; i < BHT_DEPTH; i++) begin
                bht[b][i] = '0;
            end
            for (int i = 0; i < PHT_DEPTH; i++) begin
                pht[b][i] = '0;
            end
        end
    end

    assign rd_fold = bpu_idx_fold(rd_pc_i);
    assign wr_fold = bpu_idx_fold(upd_i.pc);
    assign bht_rd_idx = rd_fold[BTB_IDX_W-1:0];
    assign bht_wr_idx = wr_fold[BTB_IDX_W-1:0];
    assign wr_bank = upd_i.pc[2];

    // pht write uses the history that made the prediction
    assign pht_wr_idx = {upd_i.history, upd_i.pc[3 +: PHT_PC_W]};

    // type miss means the old history belonged to something else
    assign hist_new = upd_i.type_miss ? {{(HIST_W-1){1'b0}}, upd_i.taken}
                                      : {upd_i.history[HIST_W-2:0], upd_i.taken};

    always_comb begin
        for (int b = 0; b < 2; b++) begin
            hist_o[b] = bht[b][bht_rd_idx];
            cnt_o[b] = pht[b][{hist_o[b], rd_pc_i[3 +: PHT_PC_W]}];
        end
    end

    always_ff @(posedge clk) begin
        if (rst_n && upd_i.update) begin
            bht[wr_bank][bht_wr_idx] <= hist_new;
            pht[wr_bank][pht_wr_idx] <= next_cnt(upd_i.cnt, upd_i.taken);
        end
    end

endmodule

// ==== source/bpu_btb.sv ====
// two-bank btb, async read, tables zeroed by initial load only, writes held off in reset
module bpu_btb import bpu_pkg::*; #(
    parameter int BTB_IDX_W = 9
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [31:0]      rd_pc_i,           // aligned pair pc
    input  logic             wr_en_i,
    input  logic [31:0]      wr_pc_i,
    input  btb_entry_t       wr_entry_i,
    output btb_entry_t [1:0] rd_entries_o,
    output logic [1:0]       hit_o
);
    localparam int DEPTH = 1 << BTB_IDX_W;

    logic [31:0]          rd_fold;
    logic [31:0]          wr_fold;
    logic [BTB_IDX_W-1:0] rd_idx;
    logic [BTB_IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0]     rd_tag;
    logic                 wr_bank;

    btb_entry_t mem [2][DEPTH];               // bank 0 even word, bank 1 odd word

    initial begin
        for (int b = 0; b < 2; b++) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[b][i] = '0;
            end
        end
    end

    assign rd_fold = bpu_idx_fold(rd_pc_i);
    assign wr_fold = bpu_idx_fold(wr_pc_i);
    assign rd_idx = rd_fold[BTB_IDX_W-1:0];   // both slots share the index
    assign wr_idx = wr_fold[BTB_IDX_W-1:0];
    assign rd_tag = bpu_tag(rd_pc_i);
    assign wr_bank = wr_pc_i[2];               // slot of the corrected instr

    // read side, one entry per bank
    always_comb begin
        for (int b = 0; b < 2; b++) begin
            rd_entries_o[b] = mem[b][rd_idx];
            hit_o[b] = rd_entries_o[b].valid && (rd_entries_o[b].tag == rd_tag);
        end
    end

    always_ff @(posedge clk) begin
        if (rst_n && wr_en_i) begin
            mem[wr_bank][wr_idx] <= wr_entry_i; // seen by next cycle's read
        end
    end

endmodule

// ==== source/bpu_pkg.sv ====
// shared types for the predictor, field widths fixed here (history 5 bits, tag pc[19:12])
package bpu_pkg;

    localparam int HIST_W = 5;                  // local history length
    localparam int TAG_W = 8;                   // btb tag, pc[19:12]
    localparam logic [31:0] INIT_PC = 32'h1c00_0000;

    typedef enum logic [1:0] {
        BR_NORMAL = 2'd0,                       // conditional
        BR_JUMP   = 2'd1,                       // direct jump, b
        BR_CALL   = 2'd2,                       // bl, pushes ras
        BR_RET    = 2'd3                        // jirl return, pops ras
    } br_type_e;

    typedef struct packed {
        logic             valid;
        br_type_e         br_type;
        logic [TAG_W-1:0] tag;
        logic [31:0]      target;
    } btb_entry_t;

    // one back end correction, history and cnt as seen at prediction time
    typedef struct packed {
        logic              update;
        logic [31:0]       pc;
        logic              taken;
        br_type_e          br_type;
        logic              is_branch;
        logic              type_miss;
        logic              target_miss;
        logic [HIST_W-1:0] history;
        logic [1:0]        cnt;
        logic [31:0]       target_pc;
    } correct_info_t;

    typedef struct packed {
        logic [31:0]       target_pc;
        logic [31:0]       next_pc;           // pc after this slot
        logic              is_branch;
        br_type_e          br_type;
        logic              taken;
        logic [1:0]        cnt;
        logic [HIST_W-1:0] history;
        logic              need_update;       // btb miss
    } predict_info_t;

    typedef struct packed {
        logic [31:0]             pc;
        logic [1:0]              mask;        // bit i set, slot i usable
        predict_info_t [1:0]     predict_infos;
    } fetch_bundle_t;

    // fold of two pc fields, caller keeps the low index bits
    // low 9 bits give pc[11:3] ^ pc[17:9]
    function automatic logic [31:0] bpu_idx_fold(input logic [31:0] pc);
        return {3'b0, pc[31:3]} ^ {9'b0, pc[31:9]};
    endfunction

    function automatic logic [TAG_W-1:0] bpu_tag(input logic [31:0] pc);
        return pc[12 +: TAG_W];
    endfunction

endpackage
